//--- hw/local_mem_cfg_pkg.sv
package local_mem_cfg_pkg;

    // ==================================================
    // Memory geometry
    // ==================================================

    // Word address width, giving 256 words in the bank
    localparam int ADDR_WIDTH = 8;
    localparam int DATA_WIDTH = 32;
    localparam int BE_WIDTH = DATA_WIDTH / 8;

    // Legal burst counts run from 1 to 7
    localparam int BURST_CNT_WIDTH = 3;

    // ==================================================
    // Pipeline stages and FIFO reserve
    // ==================================================

    // Register stages between the AFU and the command FIFO
    localparam int NUM_TIMING_REG_STAGES = 2;

    // A single waitrequest bit is assumed to travel faster than the whole bus,
    // so long pipelines get a shorter waitrequest chain
    localparam int NUM_WAITREQUEST_STAGES =
        (NUM_TIMING_REG_STAGES <= 4) ? NUM_TIMING_REG_STAGES :
        ((NUM_TIMING_REG_STAGES <= 16) ? 4 : (NUM_TIMING_REG_STAGES >> 2));

    // Slack on top of the exact in-flight count
    localparam int NUM_EXTRA_STAGES = (NUM_TIMING_REG_STAGES != 0) ? 4 : 0;

    localparam int CMD_FIFO_DEPTH = 16;

    // Free entries kept back for beats that are still in flight
    localparam int NUM_ALMFULL_SLOTS = NUM_TIMING_REG_STAGES +
                                       NUM_WAITREQUEST_STAGES +
                                       NUM_EXTRA_STAGES;

endpackage

//--- hw/avalon_mem_pkg.sv
package avalon_mem_pkg;

    import local_mem_cfg_pkg::*;

    // ==================================================
    // Command beat
    // ==================================================

    // IDLE marks a cycle that carries no beat
    typedef enum logic [1:0]
    {
        AVMM_OP_IDLE  = 2'd0,
        AVMM_OP_READ  = 2'd1,
        AVMM_OP_WRITE = 2'd2
    } avmm_op_e;

    // Later beats of a write burst use only writedata and byteenable
    typedef struct packed
    {
        avmm_op_e                   op;
        logic [ADDR_WIDTH-1:0]      address;
        logic [BURST_CNT_WIDTH-1:0] burstcount;
        logic [DATA_WIDTH-1:0]      writedata;
        logic [BE_WIDTH-1:0]        byteenable;
    } avmm_cmd_t;

    // ==================================================
    // Response beat
    // ==================================================

    // Responses are never back-pressured, so a valid bit is enough
    typedef struct packed
    {
        logic                  readdatavalid;
        logic [DATA_WIDTH-1:0] readdata;
    } avmm_rsp_t;

endpackage

//--- hw/avmm_reg_pipe.sv
`timescale 1ns/100ps

module avmm_reg_pipe
#(
    parameter int N_REG_STAGES = local_mem_cfg_pkg::NUM_TIMING_REG_STAGES,
    parameter int N_WAITREQUEST_STAGES = local_mem_cfg_pkg::NUM_WAITREQUEST_STAGES
)
(
    input  logic                    tgt_mem_afu_clk,
    input  logic                    reset,
    input  avalon_mem_pkg::avmm_cmd_t afu_cmd,
    output logic                    afu_waitrequest,
    output avalon_mem_pkg::avmm_rsp_t afu_rsp,
    output avalon_mem_pkg::avmm_cmd_t pipe_cmd,
    input  logic                    cmd_almfull,
    input  avalon_mem_pkg::avmm_rsp_t bank_rsp
);

    import avalon_mem_pkg::*;

    avmm_cmd_t cmd_pipe [N_REG_STAGES];
    avmm_rsp_t rsp_pipe [N_REG_STAGES];
    logic [N_WAITREQUEST_STAGES-1:0] wait_pipe;
    logic cmd_accept;

    // A beat is taken only when the AFU offers one and waitrequest is low
    assign cmd_accept = (afu_cmd.op != AVMM_OP_IDLE) && !afu_waitrequest;

    // ==================================================
    // Command and response pipelines
    // ==================================================

    // The FIFO reserve absorbs everything in flight, so these stages
    // never stall and behave as a plain shift register
    always_ff @(posedge tgt_mem_afu_clk)
    begin
        cmd_pipe[0] <= afu_cmd;
        if (!cmd_accept)
        begin
            cmd_pipe[0].op <= AVMM_OP_IDLE;
        end
        rsp_pipe[0] <= bank_rsp;

        for (int i = 1; i < N_REG_STAGES; i++)
        begin
            cmd_pipe[i] <= cmd_pipe[i-1];
            rsp_pipe[i] <= rsp_pipe[i-1];
        end

        // Only the op and valid bits need a known value after reset
        if (reset)
        begin
            for (int i = 0; i < N_REG_STAGES; i++)
            begin
                cmd_pipe[i].op <= AVMM_OP_IDLE;
                rsp_pipe[i].readdatavalid <= 1'b0;
            end
        end
    end

    assign pipe_cmd = cmd_pipe[N_REG_STAGES-1];
    assign afu_rsp = rsp_pipe[N_REG_STAGES-1];

    // ==================================================
    // Waitrequest delay chain
    // ==================================================

    // Almost-full from the FIFO reaches the AFU through its own shorter chain
    always_ff @(posedge tgt_mem_afu_clk)
    begin
        if (reset)
        begin
            wait_pipe <= '0;
        end
        else
        begin
            wait_pipe[0] <= cmd_almfull;
            for (int i = 1; i < N_WAITREQUEST_STAGES; i++)
            begin
                wait_pipe[i] <= wait_pipe[i-1];
            end
        end
    end

    assign afu_waitrequest = wait_pipe[N_WAITREQUEST_STAGES-1];

endmodule

//--- hw/avmm_cmd_fifo.sv
`timescale 1ns/100ps

module avmm_cmd_fifo
#(
    parameter int DEPTH = local_mem_cfg_pkg::CMD_FIFO_DEPTH,
    parameter int ALMFULL_SLOTS = local_mem_cfg_pkg::NUM_ALMFULL_SLOTS
)
(
    input  logic                    tgt_mem_afu_clk,
    input  logic                    reset,
    input  avalon_mem_pkg::avmm_cmd_t pipe_cmd,
    output logic                    cmd_almfull,
    output avalon_mem_pkg::avmm_cmd_t fifo_head,
    output logic                    fifo_valid,
    input  logic                    fifo_pop
);

    import avalon_mem_pkg::*;

    localparam int PTR_WIDTH = $clog2(DEPTH);
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    avmm_cmd_t fifo_mem [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic [CNT_WIDTH-1:0] count_next;
    logic do_push;
    logic do_pop;

    // Every real beat is pushed without a space check
    // The almost-full reserve guarantees that room exists
    assign do_push = (pipe_cmd.op != AVMM_OP_IDLE);
    assign do_pop = fifo_pop && fifo_valid;

    // Occupancy after this cycle's push and pop
    always_comb
    begin
        count_next = count;
        if (do_push && !do_pop)
        begin
            count_next = count + 1'b1;
        end
        else if (do_pop && !do_push)
        begin
            count_next = count - 1'b1;
        end
    end

    // ==================================================
    // Storage
    // ==================================================

    always_ff @(posedge tgt_mem_afu_clk)
    begin
        if (do_push)
        begin
            fifo_mem[wr_ptr] <= pipe_cmd;
        end
    end

    // Pointers, occupancy and the registered almost-full flag
    always_ff @(posedge tgt_mem_afu_clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            cmd_almfull <= 1'b0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;

            // Raised once the free entries fall to the reserve size
            cmd_almfull <= ((DEPTH - int'(count_next)) <= ALMFULL_SLOTS);
        end
    end

    // The head is visible the cycle after it was pushed
    assign fifo_head = fifo_mem[rd_ptr];
    assign fifo_valid = (count != '0);

endmodule

//--- hw/local_mem_bank.sv
`timescale 1ns/100ps

module local_mem_bank
(
    input  logic                    tgt_mem_afu_clk,
    input  logic                    reset,
    input  avalon_mem_pkg::avmm_cmd_t fifo_head,
    input  logic                    fifo_valid,
    output logic                    fifo_pop,
    output avalon_mem_pkg::avmm_rsp_t bank_rsp
);

    import local_mem_cfg_pkg::*;
    import avalon_mem_pkg::*;

    localparam int NUM_WORDS = 1 << ADDR_WIDTH;

    typedef enum logic [1:0]
    {
        BANK_IDLE,
        BANK_READ_BURST,
        BANK_WRITE_BURST
    } bank_state_e;

    bank_state_e state;
    logic [DATA_WIDTH-1:0] mem [NUM_WORDS];

    // Address of the next beat and beats still to go in the current burst
    logic [ADDR_WIDTH-1:0] burst_addr;
    logic [BURST_CNT_WIDTH-1:0] beats_left;
    logic [ADDR_WIDTH-1:0] wr_addr;

    // Replace only the bytes whose enable bit is set
    function automatic logic [DATA_WIDTH-1:0] merge_bytes(
        input logic [DATA_WIDTH-1:0] old_word,
        input logic [DATA_WIDTH-1:0] new_word,
        input logic [BE_WIDTH-1:0]   be
    );
        logic [DATA_WIDTH-1:0] merged;
        merged = old_word;
        for (int b = 0; b < BE_WIDTH; b++)
        begin
            if (be[b])
            begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    // ==================================================
    // Command consumption
    // ==================================================

    // A read burst holds off the FIFO until its last beat is out
    assign fifo_pop = fifo_valid && (state != BANK_READ_BURST);

    // The first beat of a burst carries the address, later ones follow it
    assign wr_addr = (state == BANK_IDLE) ? fifo_head.address : burst_addr;

    always_ff @(posedge tgt_mem_afu_clk)
    begin
        if (fifo_pop && (fifo_head.op == AVMM_OP_WRITE))
        begin
            mem[wr_addr] <= merge_bytes(mem[wr_addr], fifo_head.writedata,
                                        fifo_head.byteenable);
        end
    end

    always_ff @(posedge tgt_mem_afu_clk)
    begin
        if (reset)
        begin
            state <= BANK_IDLE;
            burst_addr <= '0;
            beats_left <= '0;
        end
        else
        begin
            case (state)
                BANK_IDLE:
                begin
                    if (fifo_pop && (fifo_head.op == AVMM_OP_READ))
                    begin
                        state <= BANK_READ_BURST;
                        burst_addr <= fifo_head.address;
                        beats_left <= fifo_head.burstcount;
                    end
                    else if (fifo_pop && (fifo_head.burstcount > 1))
                    begin
                        // First write beat is already stored this cycle
                        state <= BANK_WRITE_BURST;
                        burst_addr <= fifo_head.address + 1'b1;
                        beats_left <= fifo_head.burstcount - 1'b1;
                    end
                end

                BANK_WRITE_BURST:
                begin
                    if (fifo_pop)
                    begin
                        burst_addr <= burst_addr + 1'b1;
                        beats_left <= beats_left - 1'b1;
                        if (beats_left == 1)
                        begin
                            state <= BANK_IDLE;
                        end
                    end
                end

                BANK_READ_BURST:
                begin
                    // One response beat leaves in every cycle of this state
                    burst_addr <= burst_addr + 1'b1;
                    beats_left <= beats_left - 1'b1;
                    if (beats_left == 1)
                    begin
                        state <= BANK_IDLE;
                    end
                end

                default:
                begin
                    state <= BANK_IDLE;
                end
            endcase
        end
    end

    // ==================================================
    // Read response
    // ==================================================

    // Address wraps past the top word through the natural width of burst_addr
    assign bank_rsp.readdatavalid = (state == BANK_READ_BURST);
    assign bank_rsp.readdata = mem[burst_addr];

endmodule

//--- hw/local_mem_as_avalon_mem.sv
`timescale 1ns/100ps

module local_mem_as_avalon_mem
(
    input  logic                    tgt_mem_afu_clk,
    input  logic                    reset,
    input  avalon_mem_pkg::avmm_cmd_t afu_cmd,
    output logic                    afu_waitrequest,
    output avalon_mem_pkg::avmm_rsp_t afu_rsp
);

    import local_mem_cfg_pkg::*;
    import avalon_mem_pkg::*;

    avmm_cmd_t pipe_cmd;
    avmm_cmd_t fifo_head;
    avmm_rsp_t bank_rsp;
    logic cmd_almfull;
    logic fifo_valid;
    logic fifo_pop;

    // ==================================================
    // AFU side register stages
    // ==================================================

    // The FIFO behind these stages turns waitrequest into almost-full,
    // so the stages run as a simple pipeline
    avmm_reg_pipe
    #(
        .N_REG_STAGES         (NUM_TIMING_REG_STAGES),
        .N_WAITREQUEST_STAGES (NUM_WAITREQUEST_STAGES)
    )
    i_pipe
    (
        .tgt_mem_afu_clk (tgt_mem_afu_clk),
        .reset           (reset),
        .afu_cmd         (afu_cmd),
        .afu_waitrequest (afu_waitrequest),
        .afu_rsp         (afu_rsp),
        .pipe_cmd        (pipe_cmd),
        .cmd_almfull     (cmd_almfull),
        .bank_rsp        (bank_rsp)
    );

    // Reserve covers the pipe, the waitrequest chain and some slack
    avmm_cmd_fifo
    #(
        .DEPTH         (CMD_FIFO_DEPTH),
        .ALMFULL_SLOTS (NUM_ALMFULL_SLOTS)
    )
    i_fifo
    (
        .tgt_mem_afu_clk (tgt_mem_afu_clk),
        .reset           (reset),
        .pipe_cmd        (pipe_cmd),
        .cmd_almfull     (cmd_almfull),
        .fifo_head       (fifo_head),
        .fifo_valid      (fifo_valid),
        .fifo_pop        (fifo_pop)
    );

    // ==================================================
    // Memory bank
    // ==================================================

    local_mem_bank i_bank
    (
        .tgt_mem_afu_clk (tgt_mem_afu_clk),
        .reset           (reset),
        .fifo_head       (fifo_head),
        .fifo_valid      (fifo_valid),
        .fifo_pop        (fifo_pop),
        .bank_rsp        (bank_rsp)
    );

endmodule

//--- sim/local_mem_props.sv
`timescale 1ns/100ps

module local_mem_props
(
    input logic                      tgt_mem_afu_clk,
    input logic                      reset,
    input logic                      push,
    input logic                      full,
    input logic                      waitrequest,
    input logic                      readdatavalid,
    input avalon_mem_pkg::avmm_cmd_t cmd
);

    import avalon_mem_pkg::*;

    // ==================================================
    // FIFO and port rules
    // ==================================================

    // The almost-full reserve must keep every in-flight beat out of a full FIFO
    a_no_push_when_full: assert property (@(posedge tgt_mem_afu_clk) disable iff (reset)
        !(push && full))
        else $error("Command pushed into a full FIFO");

    // From the second reset cycle on, the flops hold their reset values
    a_quiet_in_reset: assert property (@(posedge tgt_mem_afu_clk)
        (reset && $past(reset)) |-> (!waitrequest && !readdatavalid))
        else $error("Waitrequest or readdatavalid high during reset");

    // A read of zero beats has no meaning on this bus
    a_read_burstcount: assert property (@(posedge tgt_mem_afu_clk) disable iff (reset)
        ((cmd.op == AVMM_OP_READ) && !waitrequest) |-> (cmd.burstcount != '0))
        else $error("Read accepted with a burst count of zero");

    a_rdv_known: assert property (@(posedge tgt_mem_afu_clk) disable iff (reset)
        !$isunknown(readdatavalid))
        else $error("Readdatavalid is unknown");

endmodule

//--- sim/mem_scoreboard.sv
`timescale 1ns/100ps

module mem_scoreboard
(
    input  logic                      tgt_mem_afu_clk,
    input  logic                      reset,
    input  logic                      expect_quiet,
    input  avalon_mem_pkg::avmm_cmd_t afu_cmd,
    input  logic                      afu_waitrequest,
    input  avalon_mem_pkg::avmm_rsp_t afu_rsp,
    output int                        error_count,
    output int                        rsp_count,
    output int                        exp_count,
    output int                        pending,
    output int                        waitreq_cycles
);

    import local_mem_cfg_pkg::*;
    import avalon_mem_pkg::*;

    // Reference copy of the bank, updated in the order the beats were accepted
    logic [DATA_WIDTH-1:0] model [1 << ADDR_WIDTH];
    logic [DATA_WIDTH-1:0] exp_q [$];
    logic [ADDR_WIDTH-1:0] wr_addr;
    int wr_left = 0;
    int errors = 0;
    int responses = 0;
    int expected_total = 0;
    int outstanding = 0;
    int wait_cycles = 0;

    // Bytes with a clear enable bit keep their old value
    function automatic logic [DATA_WIDTH-1:0] apply_byteenable(
        input logic [DATA_WIDTH-1:0] old_word,
        input logic [DATA_WIDTH-1:0] new_word,
        input logic [BE_WIDTH-1:0]   be
    );
        logic [DATA_WIDTH-1:0] mask;
        for (int b = 0; b < BE_WIDTH; b++)
        begin
            mask[b*8 +: 8] = {8{be[b]}};
        end
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    // ==================================================
    // Sampling at the clock edge, as the DUT sees it
    // ==================================================

    always @(posedge tgt_mem_afu_clk)
    begin : sample
        logic [DATA_WIDTH-1:0] expected;
        logic [ADDR_WIDTH-1:0] rd_addr;
        // Both outputs must stay low in reset and in the quiet window after it
        if ((reset || expect_quiet) && (afu_waitrequest === 1'b1))
        begin
            errors++;
            $display("Error at %0d ns: afu_waitrequest expected 0, actual 1", $time);
        end
        if ((reset || expect_quiet) && (afu_rsp.readdatavalid === 1'b1))
        begin
            errors++;
            $display("Error at %0d ns: afu_rsp.readdatavalid expected 0, actual 1", $time);
        end
        if (!reset)
        begin
            if (afu_waitrequest === 1'b1)
            begin
                wait_cycles++;
            end
            // Responses first, a read accepted now cannot answer in the same cycle
            if (afu_rsp.readdatavalid === 1'b1)
            begin
                responses++;
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("Read data arrived at %0d ns with no read outstanding", $time);
                end
                else
                begin
                    expected = exp_q.pop_front();
                    if (afu_rsp.readdata !== expected)
                    begin
                        errors++;
                        $display("Error at %0d ns: afu_rsp.readdata expected %h, actual %h",
                                 $time, expected, afu_rsp.readdata);
                    end
                end
            end
            // A beat counts only when offered while waitrequest is low
            if ((afu_cmd.op != AVMM_OP_IDLE) && (afu_waitrequest === 1'b0))
            begin
                if (afu_cmd.op == AVMM_OP_WRITE)
                begin
                    // Only the first beat of a write burst carries address and count
                    if (wr_left == 0)
                    begin
                        wr_addr = afu_cmd.address;
                        wr_left = int'(afu_cmd.burstcount);
                    end
                    model[wr_addr] = apply_byteenable(model[wr_addr], afu_cmd.writedata,
                                                      afu_cmd.byteenable);
                    wr_addr = wr_addr + 1'b1;
                    wr_left--;
                end
                else if (afu_cmd.op == AVMM_OP_READ)
                begin
                    rd_addr = afu_cmd.address;
                    for (int k = 0; k < int'(afu_cmd.burstcount); k++)
                    begin
                        exp_q.push_back(model[rd_addr]);
                        rd_addr = rd_addr + 1'b1;
                    end
                    expected_total += int'(afu_cmd.burstcount);
                end
            end
            outstanding = exp_q.size();
        end
    end

    assign error_count = errors;
    assign rsp_count = responses;
    assign exp_count = expected_total;
    assign pending = outstanding;
    assign waitreq_cycles = wait_cycles;

endmodule

//--- sim/tb_local_mem.sv
`timescale 1ns/100ps

module tb_local_mem;

    import local_mem_cfg_pkg::*;
    import avalon_mem_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_WORDS = 1 << ADDR_WIDTH;
    localparam int MAX_BURST = (1 << BURST_CNT_WIDTH) - 1;
    localparam logic [31:0] LFSR_SEED = 32'd69190;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    localparam int BEAT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 2000;
    localparam int RUN_LIMIT = 20000;

    logic tgt_mem_afu_clk;
    logic reset;
    logic expect_quiet;
    avmm_cmd_t afu_cmd;
    logic afu_waitrequest;
    avmm_rsp_t afu_rsp;
    int sb_errors;
    int sb_rsp_count;
    int sb_exp_count;
    int sb_pending;
    int sb_waitreq_cycles;
    logic [31:0] lfsr_state;
    int tb_failures;
    int tests_run;
    int tests_failed;

    local_mem_as_avalon_mem i_dut
    (
        .tgt_mem_afu_clk (tgt_mem_afu_clk),
        .reset           (reset),
        .afu_cmd         (afu_cmd),
        .afu_waitrequest (afu_waitrequest),
        .afu_rsp         (afu_rsp)
    );

    mem_scoreboard i_sb
    (
        .tgt_mem_afu_clk (tgt_mem_afu_clk),
        .reset           (reset),
        .expect_quiet    (expect_quiet),
        .afu_cmd         (afu_cmd),
        .afu_waitrequest (afu_waitrequest),
        .afu_rsp         (afu_rsp),
        .error_count     (sb_errors),
        .rsp_count       (sb_rsp_count),
        .exp_count       (sb_exp_count),
        .pending         (sb_pending),
        .waitreq_cycles  (sb_waitreq_cycles)
    );

    // The same checker watches the FIFO and the top-level ports
    bind avmm_cmd_fifo local_mem_props i_fifo_props
    (
        .tgt_mem_afu_clk (tgt_mem_afu_clk),
        .reset           (reset),
        .push            (do_push),
        .full            (int'(count) == DEPTH),
        .waitrequest     (1'b0),
        .readdatavalid   (1'b0),
        .cmd             (pipe_cmd)
    );

    bind local_mem_as_avalon_mem local_mem_props i_port_props
    (
        .tgt_mem_afu_clk (tgt_mem_afu_clk),
        .reset           (reset),
        .push            (1'b0),
        .full            (1'b0),
        .waitrequest     (afu_waitrequest),
        .readdatavalid   (afu_rsp.readdatavalid),
        .cmd             (afu_cmd)
    );

    initial
    begin
        tgt_mem_afu_clk = 1'b0;
        forever #(CLK_PERIOD / 2) tgt_mem_afu_clk = ~tgt_mem_afu_clk;
    end

    // Last line of defense if some wait loop misbehaves
    initial
    begin
        repeat (RUN_LIMIT) @(posedge tgt_mem_afu_clk);
        $display("Run limit of %0d cycles reached before the tests finished", RUN_LIMIT);
        $display("Simulation FAILED");
        $finish;
    end

    // ==================================================
    // Random numbers and bus tasks
    // ==================================================

    // Galois LFSR, one step for every bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    // Half of the addresses sit near the top so that bursts wrap past the last word
    function automatic logic [ADDR_WIDTH-1:0] pick_address();
        if (take_bits(1) != 0)
        begin
            return ADDR_WIDTH'(NUM_WORDS - 1 - int'(take_bits(3)));
        end
        return ADDR_WIDTH'(take_bits(ADDR_WIDTH));
    endfunction

    function automatic logic [BURST_CNT_WIDTH-1:0] pick_count();
        logic [BURST_CNT_WIDTH-1:0] count;
        count = BURST_CNT_WIDTH'(take_bits(BURST_CNT_WIDTH));
        if (count == '0)
        begin
            count = 'd1;
        end
        return count;
    endfunction

    // Holds the beat from a falling edge until a rising edge sees waitrequest low
    task automatic send_beat(input avmm_cmd_t beat);
        int waited;
        waited = 0;
        @(negedge tgt_mem_afu_clk);
        afu_cmd = beat;
        while ((afu_waitrequest !== 1'b0) && (waited < BEAT_TIMEOUT))
        begin
            @(negedge tgt_mem_afu_clk);
            waited++;
        end
        if (waited >= BEAT_TIMEOUT)
        begin
            tb_failures++;
            $display("Beat not accepted within %0d cycles, waitrequest stuck high", waited);
        end
    endtask

    task automatic idle_bus();
        @(negedge tgt_mem_afu_clk);
        afu_cmd = '0;
    endtask

    task automatic write_burst(input logic [ADDR_WIDTH-1:0] addr,
                               input logic [BURST_CNT_WIDTH-1:0] count,
                               input logic full_be);
        avmm_cmd_t beat;
        for (int k = 0; k < int'(count); k++)
        begin
            beat.op = AVMM_OP_WRITE;
            beat.address = addr;
            beat.burstcount = count;
            beat.writedata = take_bits(DATA_WIDTH);
            beat.byteenable = full_be ? '1 : BE_WIDTH'(take_bits(BE_WIDTH));
            send_beat(beat);
        end
    endtask

    task automatic read_burst(input logic [ADDR_WIDTH-1:0] addr,
                              input logic [BURST_CNT_WIDTH-1:0] count);
        avmm_cmd_t beat;
        beat = '0;
        beat.op = AVMM_OP_READ;
        beat.address = addr;
        beat.burstcount = count;
        send_beat(beat);
    endtask

    // Waits until every queued read word has come back
    task automatic wait_drain();
        int waited;
        waited = 0;
        idle_bus();
        while ((sb_pending != 0) && (waited < DRAIN_TIMEOUT))
        begin
            @(negedge tgt_mem_afu_clk);
            waited++;
        end
        if (sb_pending != 0)
        begin
            tb_failures++;
            $display("%0d read words still missing after %0d cycles", sb_pending, waited);
        end
    endtask

    task automatic end_test(input int num, input string name, input int errors_before);
        int new_errors;
        new_errors = sb_errors + tb_failures - errors_before;
        tests_run++;
        if (new_errors != 0)
        begin
            tests_failed++;
            $display("Test %0d %s: fail, %0d errors", num, name, new_errors);
        end
        else
        begin
            $display("Test %0d %s: pass", num, name);
        end
    endtask

    // ==================================================
    // Tests
    // ==================================================

    task automatic test_reset();
        int errors_before;
        errors_before = sb_errors + tb_failures;
        repeat (2) @(posedge tgt_mem_afu_clk);
        @(negedge tgt_mem_afu_clk);
        reset = 1'b0;
        // Nothing is offered yet, so both outputs must stay low
        expect_quiet = 1'b1;
        repeat (4) @(negedge tgt_mem_afu_clk);
        expect_quiet = 1'b0;
        end_test(1, "reset", errors_before);
    endtask

    // Every word gets a full write first, so later reads never see an unwritten word
    task automatic fill_memory();
        int base;
        int count;
        base = 0;
        while (base < NUM_WORDS)
        begin
            count = (NUM_WORDS - base < MAX_BURST) ? NUM_WORDS - base : MAX_BURST;
            write_burst(ADDR_WIDTH'(base), BURST_CNT_WIDTH'(count), 1'b1);
            base += count;
        end
        wait_drain();
    endtask

    task automatic test_byte_enables();
        logic [ADDR_WIDTH-1:0] addrs [8];
        int errors_before;
        errors_before = sb_errors + tb_failures;
        fill_memory();
        for (int i = 0; i < 8; i++)
        begin
            addrs[i] = ADDR_WIDTH'(take_bits(ADDR_WIDTH));
            write_burst(addrs[i], 'd1, 1'b0);
        end
        for (int i = 0; i < 8; i++)
        begin
            read_burst(addrs[i], 'd1);
        end
        wait_drain();
        end_test(2, "byte enables", errors_before);
    endtask

    task automatic test_random_bursts();
        logic [ADDR_WIDTH-1:0] addr;
        logic [BURST_CNT_WIDTH-1:0] count;
        int errors_before;
        errors_before = sb_errors + tb_failures;
        for (int i = 0; i < 40; i++)
        begin
            addr = pick_address();
            count = pick_count();
            if (take_bits(1) != 0)
            begin
                write_burst(addr, count, 1'b0);
            end
            else
            begin
                read_burst(addr, count);
            end
        end
        wait_drain();
        end_test(3, "random bursts", errors_before);
    endtask

    // Long reads fill the FIFO faster than the bank drains it
    task automatic test_read_backpressure();
        int errors_before;
        int rsp_before;
        int wait_before;
        int got;
        errors_before = sb_errors + tb_failures;
        rsp_before = sb_rsp_count;
        wait_before = sb_waitreq_cycles;
        for (int i = 0; i < 14; i++)
        begin
            read_burst(pick_address(), BURST_CNT_WIDTH'(MAX_BURST));
        end
        wait_drain();
        got = sb_rsp_count - rsp_before;
        if (sb_waitreq_cycles == wait_before)
        begin
            tb_failures++;
            $display("Waitrequest never rose during back-to-back reads");
        end
        if (got != 14 * MAX_BURST)
        begin
            tb_failures++;
            $display("Error at %0d ns: response count expected %0d, actual %0d",
                     $time, 14 * MAX_BURST, got);
        end
        end_test(4, "read back-pressure", errors_before);
    endtask

    task automatic test_read_after_write();
        logic [ADDR_WIDTH-1:0] addr;
        int errors_before;
        errors_before = sb_errors + tb_failures;
        for (int i = 0; i < 4; i++)
        begin
            addr = pick_address();
            write_burst(addr, BURST_CNT_WIDTH'(MAX_BURST), 1'b0);
            read_burst(addr + ADDR_WIDTH'(2), 'd5);
            read_burst(addr, BURST_CNT_WIDTH'(MAX_BURST));
        end
        wait_drain();
        end_test(5, "read after write", errors_before);
    endtask

    initial
    begin
        reset = 1'b1;
        expect_quiet = 1'b0;
        afu_cmd = '0;
        lfsr_state = LFSR_SEED;
        tb_failures = 0;
        tests_run = 0;
        tests_failed = 0;
        test_reset();
        test_byte_enables();
        test_random_bursts();
        test_read_backpressure();
        test_read_after_write();
        $display("Tests run %0d, failed %0d, errors %0d, read words checked %0d of %0d",
                 tests_run, tests_failed, sb_errors + tb_failures, sb_rsp_count,
                 sb_exp_count);
        if ((tests_failed == 0) && (sb_errors + tb_failures == 0))
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
hw/local_mem_cfg_pkg.sv
hw/avalon_mem_pkg.sv
hw/avmm_reg_pipe.sv
hw/avmm_cmd_fifo.sv
hw/local_mem_bank.sv
hw/local_mem_as_avalon_mem.sv
sim/local_mem_props.sv
sim/mem_scoreboard.sv
sim/tb_local_mem.sv

//--- Makefile
TOP = tb_local_mem
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --top-module $(TOP) -f verilog.f

# A crash or a stopped run also counts as a failure
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f verilog.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "Simulation FAILED" >> $(LOG)
	cat $(LOG)
	! grep -q "Simulation FAILED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
